/* list.f */
hw/pma_bus_pkg.sv
hw/pma_region_decode.sv
hw/bus_access_execute.sv
hw/bus_result.sv
hw/pma_bus_top.sv
verification/pma_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PMA bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
EXE=pma_bus_sim

verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module pma_bus_tb \
  -Mdir "$BUILD_DIR" \
  -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi

/* verification/pma_bus_tb.sv */
//////////////////////////////////////////////////
// PMA bus front end testbench
//////////////////////////////////////////////////

module pma_bus_tb
  import pma_bus_pkg::*;
();

  localparam int    RAM_WORDS   = 64;
  localparam addr_t TOHOST      = 32'h80001000;
  localparam addr_t UART_TX     = 32'h80001080;
  // Main memory window above the catch registers
  localparam addr_t RAM_BASE    = 32'h80002000;
  localparam int    RSP_TIMEOUT = 16;
  localparam int    BURST_REQS  = 20;

  logic                    HCLK;
  logic                    arst_n_i;
  logic                    wb_cyc_i;
  logic                    wb_stb_i;
  logic                    wb_we_i;
  addr_t                   wb_adr_i;
  data_t                   wb_dat_i;
  sel_t                    wb_sel_i;
  logic                    wb_ack_o;
  logic                    wb_err_o;
  data_t                   wb_dat_o;
  pma_cfg_t  [PMA_CNT-1:0] pma_cfg_i;
  word_adr_t [PMA_CNT-1:0] pma_adr_i;
  logic                    tohost_valid_o;
  data_t                   tohost_o;
  logic                    uart_valid_o;
  logic [7:0]              uart_char_o;

  // Reference RAM, word address modulo RAM_WORDS
  data_t       model_ram [RAM_WORDS];
  logic [31:0] rng_state;
  int          errors;
  int          tests_run;
  int          tests_failed;

  // Captured by bus_access at the response
  logic        rsp_ack;
  logic        rsp_err;
  data_t       rsp_dat;
  int          rsp_lat;
  int          tohost_pulses;
  int          uart_pulses;
  int          tohost_at_rsp;
  int          uart_at_rsp;
  data_t       tohost_seen;
  logic [7:0]  uart_seen;

  pma_bus_top #(
    .RAM_WORDS (RAM_WORDS),
    .TOHOST    (TOHOST),
    .UART_TX   (UART_TX)
  ) uut (
    .HCLK           (HCLK),
    .arst_n_i       (arst_n_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_ack_o       (wb_ack_o),
    .wb_err_o       (wb_err_o),
    .wb_dat_o       (wb_dat_o),
    .pma_cfg_i      (pma_cfg_i),
    .pma_adr_i      (pma_adr_i),
    .tohost_valid_o (tohost_valid_o),
    .tohost_o       (tohost_o),
    .uart_valid_o   (uart_valid_o),
    .uart_char_o    (uart_char_o)
  );

  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  //////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic pma_cfg_t make_cfg(input pma_mode_e mode, input logic io,
                                        input logic r, input logic w);
    pma_cfg_t cfg;
    cfg.mode = mode;
    cfg.io   = io;
    cfg.r    = r;
    cfg.w    = w;
    return cfg;
  endfunction

  function automatic int model_index(input addr_t adr);
    return int'((adr >> 2) % RAM_WORDS);
  endfunction

  // Only enabled byte lanes change
  function automatic void model_write(input addr_t adr, input data_t dat, input sel_t sel);
    int idx;
    idx = model_index(adr);
    for (int b = 0; b < 4; b++) begin
      if (sel[b])
        model_ram[idx][8*b +: 8] = dat[8*b +: 8];
    end
  endfunction

  task automatic check_data(input string msg, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string msg, input logic ack, input logic err,
                            input logic exp_ack, input logic exp_err);
    if (ack !== exp_ack || err !== exp_err) begin
      $display("** Error at %0t: %s, ack/err %b/%b, expected %b/%b",
               $time, msg, ack, err, exp_ack, exp_err);
      errors++;
    end
  endtask

  task automatic check_byte(input string msg, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // Latencies and pulse counts
  task automatic check_count(input string msg, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("test %-14s %0d error(s)", name, errors - errors_before);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus driving
  //////////////////////////////////////////////////

  task automatic drive_idle();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
  endtask

  task automatic drive_request(input logic we, input addr_t adr, input data_t dat,
                               input sel_t sel);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
  endtask

  // Single access, sampled at falling edges
  task automatic bus_access(input logic we, input addr_t adr, input data_t dat,
                            input sel_t sel);
    int   n;
    logic seen;
    n             = 0;
    seen          = 1'b0;
    tohost_pulses = 0;
    uart_pulses   = 0;
    tohost_at_rsp = 0;
    uart_at_rsp   = 0;
    @(posedge HCLK);
    #1;
    drive_request(we, adr, dat, sel);
    // Accepting edge
    @(posedge HCLK);
    #1;
    drive_idle();
    while (!seen && n < RSP_TIMEOUT) begin
      @(negedge HCLK);
      n++;
      if (tohost_valid_o)
        tohost_pulses++;
      if (uart_valid_o)
        uart_pulses++;
      if (wb_ack_o || wb_err_o) begin
        seen          = 1'b1;
        rsp_ack       = wb_ack_o;
        rsp_err       = wb_err_o;
        rsp_dat       = wb_dat_o;
        tohost_at_rsp = int'(tohost_valid_o);
        uart_at_rsp   = int'(uart_valid_o);
        tohost_seen   = tohost_o;
        uart_seen     = uart_char_o;
      end
    end
    rsp_lat = n;
    if (!seen) begin
      $display("Timeout: no ack or err within %0d cycles for address %h", RSP_TIMEOUT, adr);
      errors++;
    end
    // Host pulses must not outlast the response cycle
    @(negedge HCLK);
    if (tohost_valid_o)
      tohost_pulses++;
    if (uart_valid_o)
      uart_pulses++;
  endtask

  // Access that must be answered with ack or err after 2 cycles
  task automatic access_expect(input string msg, input logic we, input addr_t adr,
                               input data_t dat, input sel_t sel, input logic exp_ack);
    bus_access(we, adr, dat, sel);
    check_resp(msg, rsp_ack, rsp_err, exp_ack, !exp_ack);
    check_count({msg, " latency"}, rsp_lat, 2);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_ram_access();
    int    e0;
    addr_t adr;
    data_t dat;
    sel_t  sel;
    e0 = errors;
    // Full words first, then partial lanes on top
    for (int i = 0; i < 8; i++) begin
      adr       = RAM_BASE + addr_t'(4 * (i % 4));
      rng_state = xorshift32(rng_state);
      dat       = rng_state;
      sel       = (i < 4) ? 4'hf : rng_state[7:4];
      access_expect("ram write", 1'b1, adr, dat, sel, 1'b1);
      model_write(adr, dat, sel);
    end
    for (int i = 0; i < 4; i++) begin
      adr = RAM_BASE + addr_t'(4 * i);
      access_expect("ram read", 1'b0, adr, '0, 4'hf, 1'b1);
      check_data("ram read data", rsp_dat, model_ram[model_index(adr)]);
    end
    report_test("ram_access", e0);
  endtask

  task automatic test_permission();
    int e0;
    e0 = errors;
    // Seed the word that region 0 aliases onto
    access_expect("alias seed", 1'b1, RAM_BASE + 32'h40, 32'hcafef00d, 4'hf, 1'b1);
    model_write(RAM_BASE + 32'h40, 32'hcafef00d, 4'hf);
    access_expect("read-only write", 1'b1, 32'h00000040, 32'h12345678, 4'hf, 1'b0);
    access_expect("read-only read", 1'b0, 32'h00000040, '0, 4'hf, 1'b1);
    check_data("aliased word", rsp_dat, model_ram[model_index(32'h00000040)]);
    access_expect("uart read", 1'b0, UART_TX, '0, 4'hf, 1'b0);
    check_data("uart read data", rsp_dat, '0);
    report_test("permission", e0);
  endtask

  task automatic test_tohost();
    int    e0;
    data_t dat;
    e0        = errors;
    rng_state = xorshift32(rng_state);
    dat       = rng_state;
    access_expect("tohost write", 1'b1, TOHOST, dat, 4'hf, 1'b1);
    check_count("tohost pulses", tohost_pulses, 1);
    check_count("tohost pulse on ack", tohost_at_rsp, 1);
    check_data("tohost value", tohost_seen, dat);
    access_expect("tohost read", 1'b0, TOHOST, '0, 4'hf, 1'b1);
    check_data("tohost read data", rsp_dat, dat);
    check_count("tohost pulses on read", tohost_pulses, 0);
    report_test("tohost", e0);
  endtask

  task automatic test_uart();
    int    e0;
    data_t dat;
    e0        = errors;
    rng_state = xorshift32(rng_state);
    dat       = rng_state;
    access_expect("uart write", 1'b1, UART_TX, dat, 4'hf, 1'b1);
    check_count("uart pulses", uart_pulses, 1);
    check_count("uart pulse on ack", uart_at_rsp, 1);
    check_byte("uart char", uart_seen, dat[7:0]);
    check_count("tohost pulses on uart", tohost_pulses, 0);
    report_test("uart", e0);
  endtask

  task automatic test_unmatched();
    int e0;
    e0 = errors;
    access_expect("above region 3", 1'b0, 32'hc0000000, '0, 4'hf, 1'b0);
    access_expect("above region 3 write", 1'b1, 32'hc0000010, 32'h1, 4'hf, 1'b0);
    access_expect("gap after window", 1'b0, 32'h80001040, '0, 4'hf, 1'b0);
    access_expect("io read off tohost", 1'b0, TOHOST + 32'h4, '0, 4'hf, 1'b0);
    access_expect("io write off tohost", 1'b1, TOHOST + 32'h8, 32'h5, 4'hf, 1'b0);
    check_count("tohost pulses on fault", tohost_pulses, 0);
    report_test("unmatched", e0);
  endtask

  // One request per cycle, response checked 2 cycles later
  task automatic test_back_to_back();
    int    e0;
    int    k;
    data_t exp_dat [BURST_REQS];
    addr_t adr;
    data_t dat;
    sel_t  sel;
    logic  we;
    e0 = errors;
    for (int j = 0; j < BURST_REQS + 2; j++) begin
      @(posedge HCLK);
      #1;
      if (j < BURST_REQS) begin
        rng_state = xorshift32(rng_state);
        adr       = RAM_BASE | {20'h0, rng_state[11:2], 2'b00};
        we        = rng_state[31];
        sel       = rng_state[15:12];
        rng_state = xorshift32(rng_state);
        dat       = rng_state;
        // Read data is zero on writes
        exp_dat[j] = we ? '0 : model_ram[model_index(adr)];
        if (we)
          model_write(adr, dat, sel);
        drive_request(we, adr, dat, sel);
      end else begin
        drive_idle();
      end
      @(negedge HCLK);
      k = j - 2;
      if (k >= 0) begin
        check_resp($sformatf("burst %0d", k), wb_ack_o, wb_err_o, 1'b1, 1'b0);
        check_data($sformatf("burst %0d data", k), wb_dat_o, exp_dat[k]);
      end else begin
        check_resp("burst idle", wb_ack_o, wb_err_o, 1'b0, 1'b0);
      end
    end
    report_test("back_to_back", e0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rng_state    = 32'h2367867b;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    arst_n_i     = 1'b0;
    drive_idle();
    // Region table, lowest index wins
    pma_cfg_i[0] = make_cfg(PMA_TOR, 1'b0, 1'b1, 1'b0);
    pma_adr_i[0] = TOHOST[31:2];
    // 8 words around TOHOST, two trailing ones
    pma_cfg_i[1] = make_cfg(PMA_NAPOT, 1'b1, 1'b1, 1'b1);
    pma_adr_i[1] = TOHOST[31:2] | 30'h3;
    pma_cfg_i[2] = make_cfg(PMA_NA4, 1'b1, 1'b0, 1'b1);
    pma_adr_i[2] = UART_TX[31:2];
    // From UART_TX up to byte 0xC000_0000
    pma_cfg_i[3] = make_cfg(PMA_TOR, 1'b0, 1'b1, 1'b1);
    pma_adr_i[3] = 30'h30000000;
    for (int i = 0; i < RAM_WORDS; i++) begin
      model_ram[i] = '0;
    end
    repeat (16) @(posedge HCLK);
    #1;
    arst_n_i = 1'b1;

    test_ram_access();
    test_permission();
    test_tohost();
    test_uart();
    test_unmatched();
    test_back_to_back();

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* hw/pma_bus_top.sv */
//////////////////////////////////////////////////
// PMA checked Wishbone data bus
//////////////////////////////////////////////////

module pma_bus_top
  import pma_bus_pkg::*;
#(
  parameter int    RAM_WORDS = 64,
  parameter addr_t TOHOST    = 32'h80001000,
  parameter addr_t UART_TX   = 32'h80001080
) (
  input  logic                     HCLK,
  input  logic                     arst_n_i,

  // Wishbone pipelined slave
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  addr_t                    wb_adr_i,
  input  data_t                    wb_dat_i,
  input  sel_t                     wb_sel_i,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,
  output data_t                    wb_dat_o,

  // Region table
  input  pma_cfg_t  [PMA_CNT-1:0]  pma_cfg_i,
  input  word_adr_t [PMA_CNT-1:0]  pma_adr_i,

  // Host catches
  output logic                     tohost_valid_o,
  output data_t                    tohost_o,
  output logic                     uart_valid_o,
  output logic [7:0]               uart_char_o
);

  // Stage to stage items
  dec_item_t dec;
  exe_item_t exe;

  //////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////

  pma_region_decode #(
    .TOHOST  (TOHOST),
    .UART_TX (UART_TX)
  ) u_decode (
    .HCLK      (HCLK),
    .arst_n_i  (arst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .pma_cfg_i (pma_cfg_i),
    .pma_adr_i (pma_adr_i),
    .dec_o     (dec)
  );

  bus_access_execute #(
    .RAM_WORDS (RAM_WORDS)
  ) u_execute (
    .HCLK           (HCLK),
    .arst_n_i       (arst_n_i),
    .dec_i          (dec),
    .exe_o          (exe),
    .tohost_valid_o (tohost_valid_o),
    .tohost_o       (tohost_o),
    .uart_valid_o   (uart_valid_o),
    .uart_char_o    (uart_char_o)
  );

  // Purely combinational, response in cycle 2
  bus_result u_result (
    .exe_i    (exe),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .wb_dat_o (wb_dat_o)
  );

endmodule

/* hw/bus_result.sv */
//////////////////////////////////////////////////
// Result stage
// Wishbone response
//////////////////////////////////////////////////

module bus_result
  import pma_bus_pkg::*;
(
  input  exe_item_t exe_i,

  // Wishbone response
  output logic      wb_ack_o,
  output logic      wb_err_o,
  output data_t     wb_dat_o
);

  logic rd_ack;

  //////////////////////////////////////////////////
  // Response forming
  //////////////////////////////////////////////////

  // One of ack or err per live item
  assign wb_ack_o = exe_i.valid & ~exe_i.fault;
  assign wb_err_o = exe_i.valid &  exe_i.fault;

  // Data only returned on a good read
  assign rd_ack   = wb_ack_o & ~exe_i.we;
  assign wb_dat_o = rd_ack ? exe_i.rdata : '0;

  // No clock at this stage, checked combinationally
  always_comb begin
    a_ack_err_excl: assert (!(wb_ack_o && wb_err_o))
      else $error("ack and err high together");
  end

endmodule

/* hw/bus_access_execute.sv */
//////////////////////////////////////////////////
// Execute stage
// On-chip RAM and host catch registers
//////////////////////////////////////////////////

module bus_access_execute
  import pma_bus_pkg::*;
#(
  parameter int RAM_WORDS = 64
) (
  input  logic       HCLK,
  input  logic       arst_n_i,

  input  dec_item_t  dec_i,
  output exe_item_t  exe_o,

  // Host side, single-cycle pulses
  output logic       tohost_valid_o,
  output data_t      tohost_o,
  output logic       uart_valid_o,
  output logic [7:0] uart_char_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  data_t              ram [RAM_WORDS];
  data_t              tohost_q;
  exe_item_t          exe_q;
  logic [IDX_W-1:0]   ram_idx;
  logic               is_write;
  logic               ram_we;
  logic               tohost_we;
  logic               uart_we;
  data_t              rdata;

  //////////////////////////////////////////////////
  // Access decode
  //////////////////////////////////////////////////

  // Word address modulo RAM_WORDS
  assign ram_idx  = dec_i.req.adr[IDX_W+1:2];
  assign is_write = dec_i.valid && dec_i.req.we;

  // Faulted items never reach these
  assign ram_we    = is_write && (dec_i.target == TGT_RAM);
  assign tohost_we = is_write && (dec_i.target == TGT_TOHOST);
  assign uart_we   = is_write && (dec_i.target == TGT_UART);

  // Read mux, old contents on a same-edge write
  always_comb begin
    rdata = '0;
    if (!dec_i.req.we) begin
      case (dec_i.target)
        TGT_RAM:    rdata = ram[ram_idx];
        TGT_TOHOST: rdata = tohost_q;
        default:    rdata = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // State update
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // RAM starts out cleared
      for (int i = 0; i < RAM_WORDS; i++) begin
        ram[i] <= '0;
      end
      tohost_q       <= '0;
      exe_q          <= '0;
      tohost_valid_o <= 1'b0;
      uart_valid_o   <= 1'b0;
    end else begin
      // Byte-lane write
      if (ram_we) begin
        for (int b = 0; b < $bits(sel_t); b++) begin
          if (dec_i.req.sel[b]) begin
            ram[ram_idx][8*b +: 8] <= dec_i.req.dat[8*b +: 8];
          end
        end
      end

      // TOHOST takes the whole word
      if (tohost_we) begin
        tohost_q <= dec_i.req.dat;
      end
      tohost_valid_o <= tohost_we;
      uart_valid_o   <= uart_we;

      // Item to the result stage
      exe_q.valid <= dec_i.valid;
      exe_q.fault <= dec_i.valid && (dec_i.target == TGT_FAULT);
      exe_q.we    <= dec_i.req.we;
      exe_q.rdata <= rdata;
    end
  end

  // UART character, only meaningful with its pulse
  always_ff @(posedge HCLK) begin
    if (uart_we) begin
      uart_char_o <= dec_i.req.dat[7:0];
    end
  end

  assign tohost_o = tohost_q;
  assign exe_o    = exe_q;

  // One write goes to one catch register
  a_host_excl: assert property (@(posedge HCLK) disable iff (!arst_n_i)
    !(tohost_valid_o && uart_valid_o));

endmodule

/* hw/pma_region_decode.sv */
//////////////////////////////////////////////////
// Decode stage
// Region match and permission check
//////////////////////////////////////////////////

module pma_region_decode
  import pma_bus_pkg::*;
#(
  parameter addr_t TOHOST  = 32'h80001000,
  parameter addr_t UART_TX = 32'h80001080
) (
  input  logic                     HCLK,
  input  logic                     arst_n_i,

  // Wishbone request
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  addr_t                    wb_adr_i,
  input  data_t                    wb_dat_i,
  input  sel_t                     wb_sel_i,

  // Region table, held stable
  input  pma_cfg_t  [PMA_CNT-1:0]  pma_cfg_i,
  input  word_adr_t [PMA_CNT-1:0]  pma_adr_i,

  output dec_item_t                dec_o
);

  // Catch register word addresses
  localparam word_adr_t TOHOST_W  = TOHOST[31:2];
  localparam word_adr_t UART_TX_W = UART_TX[31:2];

  logic               accept;
  logic               valid_q;
  bus_req_t           req_q;
  word_adr_t          req_wadr;
  logic [PMA_CNT-1:0] region_match;
  logic               hit;
  pma_cfg_t           hit_cfg;
  logic               at_tohost;
  logic               at_uart;
  target_e            target;

  //////////////////////////////////////////////////
  // Request capture
  //////////////////////////////////////////////////

  // No stall, every strobe is taken
  assign accept = wb_cyc_i & wb_stb_i;

  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  // Payload only
  always_ff @(posedge HCLK) begin
    if (accept) begin
      req_q.adr <= wb_adr_i;
      req_q.dat <= wb_dat_i;
      req_q.sel <= wb_sel_i;
      req_q.we  <= wb_we_i;
    end
  end

  assign req_wadr = req_q.adr[31:2];

  //////////////////////////////////////////////////
  // Region match, all regions in parallel
  //////////////////////////////////////////////////

  for (genvar i = 0; i < PMA_CNT; i++) begin : g_region
    word_adr_t lo_adr;
    word_adr_t napot_mask;

    // TOR lower bound is the previous region's address
    if (i == 0) begin : g_first
      assign lo_adr = '0;
    end else begin : g_next
      assign lo_adr = pma_adr_i[i-1];
    end

    // k trailing ones -> low k+1 bits ignored
    assign napot_mask = ~(pma_adr_i[i] ^ (pma_adr_i[i] + 1'b1));

    always_comb begin
      case (pma_cfg_i[i].mode)
        PMA_TOR:   region_match[i] = (req_wadr >= lo_adr) && (req_wadr < pma_adr_i[i]);
        PMA_NA4:   region_match[i] = (req_wadr == pma_adr_i[i]);
        PMA_NAPOT: region_match[i] = ((req_wadr ^ pma_adr_i[i]) & napot_mask) == '0;
        default:   region_match[i] = 1'b0;
      endcase
    end
  end

  // Lowest index wins, so scan downward
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (region_match[i]) begin
        hit     = 1'b1;
        hit_cfg = pma_cfg_i[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Permission check and target select
  //////////////////////////////////////////////////

  assign at_tohost = (req_wadr == TOHOST_W);
  assign at_uart   = (req_wadr == UART_TX_W);

  always_comb begin
    target = TGT_FAULT;
    if (hit) begin
      if (req_q.we ? !hit_cfg.w : !hit_cfg.r) begin
        target = TGT_FAULT;
      end else if (hit_cfg.io) begin
        // Only the two catch registers live in I/O space
        if (at_tohost) begin
          target = TGT_TOHOST;
        end else if (at_uart && req_q.we) begin
          target = TGT_UART;
        end
      end else begin
        target = TGT_RAM;
      end
    end
  end

  assign dec_o.valid  = valid_q;
  assign dec_o.req    = req_q;
  assign dec_o.target = target;

  // Decoded target must resolve once the item is live
  a_target_known: assert property (@(posedge HCLK) disable iff (!arst_n_i)
    dec_o.valid |-> !$isunknown(dec_o.target));

endmodule

/* hw/pma_bus_pkg.sv */
//////////////////////////////////////////////////
// PMA bus front end
// Shared types and widths
//////////////////////////////////////////////////

package pma_bus_pkg;

  // Number of PMA regions in the table
  localparam int PMA_CNT = 4;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // Byte address
  typedef logic [31:0] addr_t;
  // Bus word
  typedef logic [31:0] data_t;
  // Byte enables, one per byte lane
  typedef logic [3:0]  sel_t;
  // Word address, byte address >> 2
  typedef logic [29:0] word_adr_t;

  //////////////////////////////////////////////////
  // Region configuration
  //////////////////////////////////////////////////

  // Address matching modes, same encoding as pmpcfg.A
  typedef enum logic [1:0] {
    PMA_OFF   = 2'd0,
    PMA_TOR   = 2'd1,
    PMA_NA4   = 2'd2,
    PMA_NAPOT = 2'd3
  } pma_mode_e;

  typedef struct packed {
    pma_mode_e mode;
    logic      io;  // I/O region, else main memory
    logic      r;
    logic      w;
  } pma_cfg_t;

  //////////////////////////////////////////////////
  // Pipeline items
  //////////////////////////////////////////////////

  typedef struct packed {
    addr_t adr;
    data_t dat;
    sel_t  sel;
    logic  we;
  } bus_req_t;

  // Where a decoded access goes
  typedef enum logic [1:0] {
    TGT_RAM    = 2'd0,
    TGT_TOHOST = 2'd1,
    TGT_UART   = 2'd2,
    TGT_FAULT  = 2'd3
  } target_e;

  // Decode -> execute
  typedef struct packed {
    logic     valid;
    bus_req_t req;
    target_e  target;
  } dec_item_t;

  // Execute -> result
  typedef struct packed {
    logic  valid;
    logic  fault;
    logic  we;  // write flag, kept to zero read data on writes
    data_t rdata;
  } exe_item_t;

endpackage
